/* vvadd_xcel.f */
hdl/vvadd_bus_pkg.sv
hdl/vvadd_xcel_pkg.sv
hdl/vvadd_host_regs.sv
hdl/vvadd_engine.sv
hdl/vvadd_scratchpad.sv
hdl/vvadd_xcel.sv
verification/tb_vvadd_mem_model.sv
verification/tb_vvadd_xcel.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the vvadd testbench with Verilator, then judge the run from its log
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module tb_vvadd_xcel -f vvadd_xcel.f \
    || { echo "build failed"; exit 1; }

./obj_dir/Vtb_vvadd_xcel > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

grep -q "TESTBENCH FAILED" sim.log || ! grep -q "TESTBENCH PASSED" sim.log \
    && { echo "simulation failed"; exit 1; }
echo "simulation passed"

/* verification/tb_vvadd_xcel.sv */
// testbench top: clock, reset, host stimulus, bus checkers and reporting
module tb_vvadd_xcel
    import vvadd_bus_pkg::*;
    import vvadd_xcel_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period   = 40;
    localparam int max_ack_wait = 3;
    localparam int run1_n       = 12;
    localparam int run2_n       = 20;
    // two fetches at worst-case wait, three add cycles and one host read per element
    localparam int cycles_per_elem = 2 * (max_ack_wait + 2) + 3 + 3;
    localparam int timeout_cycles  = (run1_n + run2_n) * cycles_per_elem + 300;

    logic                      clk;
    logic                      reset;
    logic                      s_cyc;
    logic                      s_stb;
    logic                      s_we;
    host_addr_u                s_adr;
    logic [bus_data_width-1:0] s_dat_w;
    logic [bus_data_width-1:0] s_dat_r;
    logic [bus_sel_width-1:0]  s_sel;
    logic                      s_ack;
    logic                      m_cyc;
    logic                      m_stb;
    logic                      m_we;
    logic [bus_addr_width-1:0] m_adr;
    logic [bus_data_width-1:0] m_dat_w;
    logic [bus_data_width-1:0] m_dat_r;
    logic                      m_ack;
    int unsigned               sig_writes;

    // checker state
    logic                      rd_check;
    logic [bus_data_width-1:0] rd_expect;
    logic                      run_active;
    int unsigned               run_n;
    logic [bus_addr_width-1:0] run_a;
    logic [bus_addr_width-1:0] run_b;
    logic [bus_addr_width-1:0] run_sig;
    int unsigned               rd_seen;
    int unsigned               wr_seen;
    logic [bus_addr_width-1:0] rd_adr_exp;
    int unsigned               errors;
    int unsigned               test_count;
    int unsigned               errs_before;

    always #(clk_period / 2) clk = ~clk;

    vvadd_xcel dut0 (
        .clk_i   (clk),
        .reset_i (reset),
        .s_cyc_i (s_cyc),
        .s_stb_i (s_stb),
        .s_we_i  (s_we),
        .s_adr_i (s_adr),
        .s_dat_i (s_dat_w),
        .s_sel_i (s_sel),
        .s_dat_o (s_dat_r),
        .s_ack_o (s_ack),
        .m_cyc_o (m_cyc),
        .m_stb_o (m_stb),
        .m_we_o  (m_we),
        .m_adr_o (m_adr),
        .m_dat_o (m_dat_w),
        .m_dat_i (m_dat_r),
        .m_ack_i (m_ack)
    );

    tb_vvadd_mem_model mem0 (
        .clk_i       (clk),
        .reset_i     (reset),
        .cyc_i       (m_cyc),
        .stb_i       (m_stb),
        .we_i        (m_we),
        .adr_i       (m_adr),
        .dat_o       (m_dat_r),
        .ack_o       (m_ack),
        .sig_count_o (sig_writes)
    );

    // ------------------------------------------------------------
    // master traffic within the current run
    // ------------------------------------------------------------

    always @(posedge clk) begin
        if (!run_active) begin
            rd_seen <= 0;
            wr_seen <= 0;
        end else if (m_cyc && m_stb && m_ack) begin
            if (m_we) begin
                wr_seen <= wr_seen + 1;
            end else begin
                rd_seen <= rd_seen + 1;
            end
        end
    end

    // first n reads walk A, the next n walk B
    assign rd_adr_exp = (rd_seen < run_n) ? run_a + rd_seen : run_b + (rd_seen - run_n);

    // ------------------------------------------------------------
    // checkers
    // ------------------------------------------------------------

    host_ack_next: assert property (@(posedge clk) disable iff (reset)
        (s_cyc && s_stb && !s_ack) |=> s_ack)
        else begin
            errors = errors + 1;
            $display("host ack did not follow the request by one cycle at %0t", $time);
        end

    host_ack_after_req: assert property (@(posedge clk) disable iff (reset)
        s_ack |-> $past(s_cyc && s_stb && !s_ack))
        else begin
            errors = errors + 1;
            $display("host ack seen without a new request at %0t", $time);
        end

    host_read_data: assert property (@(posedge clk) disable iff (reset)
        (s_ack && rd_check) |-> (s_dat_r == rd_expect))
        else begin
            errors = errors + 1;
            $display("ERROR s_dat_o expected %h got %h", $sampled(rd_expect), $sampled(s_dat_r));
        end

    master_req_stable: assert property (@(posedge clk) disable iff (reset)
        (m_stb && !m_ack) |=> (m_stb && $stable(m_adr) && $stable(m_we) && $stable(m_dat_w)))
        else begin
            errors = errors + 1;
            $display("master request changed before its ack at %0t", $time);
        end

    master_read_order: assert property (@(posedge clk) disable iff (reset)
        (m_cyc && m_stb && !m_we && m_ack) |-> (m_adr == rd_adr_exp))
        else begin
            errors = errors + 1;
            $display("ERROR m_adr_o expected %h got %h", $sampled(rd_adr_exp), $sampled(m_adr));
        end

    master_read_count: assert property (@(posedge clk) disable iff (reset)
        (m_cyc && m_stb && m_we && m_ack) |-> (rd_seen == 2 * run_n))
        else begin
            errors = errors + 1;
            $display("wrong number of master reads before the completion write: %0d of %0d",
                     $sampled(rd_seen), 2 * $sampled(run_n));
        end

    sig_write_addr: assert property (@(posedge clk) disable iff (reset)
        (m_cyc && m_stb && m_we && m_ack) |-> (m_adr == run_sig))
        else begin
            errors = errors + 1;
            $display("ERROR m_adr_o expected %h got %h", $sampled(run_sig), $sampled(m_adr));
        end

    sig_write_data: assert property (@(posedge clk) disable iff (reset)
        (m_cyc && m_stb && m_we && m_ack) |-> (m_dat_w == 32'd1))
        else begin
            errors = errors + 1;
            $display("ERROR m_dat_o expected %h got %h", 32'd1, $sampled(m_dat_w));
        end

    sig_write_once: assert property (@(posedge clk) disable iff (reset)
        (m_cyc && m_stb && m_we && m_ack) |-> (wr_seen == 0))
        else begin
            errors = errors + 1;
            $display("more than one completion write in a run at %0t", $time);
        end

    master_quiet_when_idle: assert property (@(posedge clk) disable iff (reset)
        (m_cyc || m_stb) |-> run_active)
        else begin
            errors = errors + 1;
            $display("master bus active outside a run at %0t", $time);
        end

    // ------------------------------------------------------------
    // host helpers
    // ------------------------------------------------------------

    function automatic host_addr_u reg_addr(input logic [2:0] index);
        host_addr_u adr;
        adr           = '0;
        adr.csr.index = index;
        return adr;
    endfunction

    function automatic host_addr_u spad_addr(input logic [5:0] index);
        host_addr_u adr;
        adr            = '0;
        adr.mem.region = 1'b1;
        adr.mem.index  = index;
        return adr;
    endfunction

    // word seen after a byte-masked write over old_word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                merged[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic host_access(input host_addr_u adr, input logic we,
                               input logic [31:0] wdata, input logic [3:0] sel,
                               input logic check, input logic [31:0] exp_data);
        @(posedge clk);
        s_cyc     <= 1'b1;
        s_stb     <= 1'b1;
        s_we      <= we;
        s_adr     <= adr;
        s_dat_w   <= wdata;
        s_sel     <= sel;
        rd_check  <= check;
        rd_expect <= exp_data;
        @(posedge clk);
        while (!s_ack) begin
            @(posedge clk);
        end
        s_cyc    <= 1'b0;
        s_stb    <= 1'b0;
        s_we     <= 1'b0;
        rd_check <= 1'b0;
    endtask

    task automatic write_reg(input logic [2:0] index, input logic [31:0] data);
        host_access(reg_addr(index), 1'b1, data, 4'hf, 1'b0, '0);
    endtask

    task automatic check_reg(input logic [2:0] index, input logic [31:0] exp_data);
        host_access(reg_addr(index), 1'b0, '0, 4'hf, 1'b1, exp_data);
    endtask

    task automatic write_spad(input logic [5:0] index, input logic [31:0] data,
                              input logic [3:0] sel);
        host_access(spad_addr(index), 1'b1, data, sel, 1'b0, '0);
    endtask

    task automatic check_spad(input logic [5:0] index, input logic [31:0] exp_data);
        host_access(spad_addr(index), 1'b0, '0, 4'hf, 1'b1, exp_data);
    endtask

    task automatic load_config(input int n, input int dst, input logic [31:0] a,
                               input logic [31:0] b, input logic [31:0] sig);
        write_reg(csr_dst, 32'(dst));
        write_reg(csr_nelem, 32'(n));
        write_reg(csr_a_addr, a);
        write_reg(csr_b_addr, b);
        write_reg(csr_sig_addr, sig);
        run_n   = n;
        run_a   = a;
        run_b   = b;
        run_sig = sig;
    endtask

    // start the engine and wait for its completion write
    task automatic run_vvadd();
        int unsigned sig_before;
        @(posedge clk);
        run_active <= 1'b1;
        sig_before = sig_writes;
        write_reg(csr_cmd, 32'd1);
        while (sig_writes == sig_before) begin
            @(posedge clk);
        end
    endtask

    // any master traffic after this is outside a run
    task automatic end_run();
        @(posedge clk);
        run_active <= 1'b0;
    endtask

    task automatic check_sums(input int n, input int dst, input logic [31:0] a,
                              input logic [31:0] b);
        logic [31:0] sum;
        for (int i = 0; i < n; i++) begin
            sum = mem0.words[8'(a + i)] + mem0.words[8'(b + i)];
            check_spad(6'(dst + i), sum);
        end
    endtask

    task automatic report_test(input string name);
        // checks of the last ack settle one edge later
        @(posedge clk);
        test_count = test_count + 1;
        if (errors == errs_before) begin
            $display("test %0d, %s: ok", test_count, name);
        end else begin
            $display("test %0d, %s: %0d check(s) failed", test_count, name, errors - errs_before);
        end
        errs_before = errors;
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    initial begin
        void'($urandom(32'hd7ed_a34c));
        clk         = 1'b0;
        reset       = 1'b1;
        s_cyc       = 1'b0;
        s_stb       = 1'b0;
        s_we        = 1'b0;
        s_adr       = '0;
        s_dat_w     = '0;
        s_sel       = '0;
        rd_check    = 1'b0;
        rd_expect   = '0;
        run_active  = 1'b0;
        run_n       = 0;
        run_a       = '0;
        run_b       = '0;
        run_sig     = '0;
        errors      = 0;
        test_count  = 0;
        errs_before = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        load_config(run1_n, 4, 32'h0000_0020, 32'h0000_0060, 32'h8000_00f0);
        check_reg(csr_dst, 32'd4);
        check_reg(csr_nelem, 32'(run1_n));
        check_reg(csr_a_addr, 32'h0000_0020);
        check_reg(csr_b_addr, 32'h0000_0060);
        check_reg(csr_sig_addr, 32'h8000_00f0);
        report_test("register write and readback");

        write_spad(6'd63, 32'h1122_3344, 4'hf);
        write_spad(6'd63, 32'haabb_ccdd, 4'b0101);
        check_spad(6'd63, merge_bytes(32'h1122_3344, 32'haabb_ccdd, 4'b0101));
        write_spad(6'd63, 32'h5566_7788, 4'b1000);
        check_spad(6'd63, merge_bytes(32'h11bb_33dd, 32'h5566_7788, 4'b1000));
        report_test("scratchpad byte selects");

        run_vvadd();
        check_reg(csr_cmd, 32'd1);
        report_test("run 1 fetch order and completion write");

        check_sums(run1_n, 4, 32'h0000_0020, 32'h0000_0060);
        end_run();
        report_test("run 1 sums");

        load_config(run2_n, 20, 32'h0000_0090, 32'h0000_00c0, 32'h8000_0ff4);
        run_vvadd();
        check_sums(run2_n, 20, 32'h0000_0090, 32'h0000_00c0);
        end_run();
        assert (sig_writes == 2)
        else begin
            errors = errors + 1;
            $display("expected two completion writes in total, saw %0d", sig_writes);
        end
        report_test("run 2 with new length and destination");

        $display("%0d tests run, %0d checks failed", test_count, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the run did not finish", timeout_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* verification/tb_vvadd_mem_model.sv */
// external word memory for the master port, random ack delays, completion write count
module tb_vvadd_mem_model
    import vvadd_bus_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      cyc_i,
    input  logic                      stb_i,
    input  logic                      we_i,
    input  logic [bus_addr_width-1:0] adr_i,
    output logic [bus_data_width-1:0] dat_o,
    output logic                      ack_o,
    output int unsigned               sig_count_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int mem_words = 256;
    localparam int max_wait  = 3;

    logic [bus_data_width-1:0] words [mem_words];
    logic                      pending_r;
    int unsigned               wait_r;
    int unsigned               wait_now;

    initial begin
        dat_o       = '0;
        ack_o       = 1'b0;
        sig_count_o = 0;
        pending_r   = 1'b0;
        wait_r      = 0;
    end

    always @(posedge clk_i) begin
        if (reset_i) begin
            ack_o     <= 1'b0;
            pending_r <= 1'b0;
            wait_r    <= 0;
            // A and B are plain random words
            for (int i = 0; i < mem_words; i++) begin
                words[i] <= $urandom;
            end
        end else if (ack_o) begin
            // master moves on in the cycle after an ack
            ack_o <= 1'b0;
        end else if (cyc_i && stb_i) begin
            wait_now = pending_r ? wait_r : $urandom_range(max_wait, 0);
            if (wait_now == 0) begin
                ack_o     <= 1'b1;
                pending_r <= 1'b0;
                if (we_i) begin
                    sig_count_o <= sig_count_o + 1;
                end else begin
                    dat_o <= words[adr_i[7:0]];
                end
            end else begin
                pending_r <= 1'b1;
                wait_r    <= wait_now - 1;
            end
        end
    end

endmodule

/* hdl/vvadd_xcel.sv */
// vvadd accelerator top: host registers, engine and scratchpad
module vvadd_xcel
    import vvadd_bus_pkg::*;
    import vvadd_xcel_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_i,
    // host slave port
    input  logic                      s_cyc_i,
    input  logic                      s_stb_i,
    input  logic                      s_we_i,
    input  host_addr_u                s_adr_i,
    input  logic [bus_data_width-1:0] s_dat_i,
    input  logic [bus_sel_width-1:0]  s_sel_i,
    output logic [bus_data_width-1:0] s_dat_o,
    output logic                      s_ack_o,
    // memory master port
    output logic                      m_cyc_o,
    output logic                      m_stb_o,
    output logic                      m_we_o,
    output logic [bus_addr_width-1:0] m_adr_o,
    output logic [bus_data_width-1:0] m_dat_o,
    input  logic [bus_data_width-1:0] m_dat_i,
    input  logic                      m_ack_i
);

    // ------------------------------------------------------------
    // configuration from registers to engine
    // ------------------------------------------------------------

    logic                        start;
    logic [spad_index_width-1:0] dst;
    logic [count_width-1:0]      nelem;
    logic [bus_addr_width-1:0]   a_addr;
    logic [bus_addr_width-1:0]   b_addr;
    logic [bus_addr_width-1:0]   sig_addr;

    // scratchpad port 0, host side
    logic                        host_en;
    logic                        host_we;
    logic [spad_index_width-1:0] host_index;
    logic [bus_data_width-1:0]   host_wdata;
    logic [bus_sel_width-1:0]    host_sel;
    logic [bus_data_width-1:0]   host_rdata;

    // scratchpad port 1, engine side
    logic                        eng_en;
    logic                        eng_we;
    logic [spad_index_width-1:0] eng_index;
    logic [bus_data_width-1:0]   eng_wdata;
    logic [bus_data_width-1:0]   eng_rdata;

    vvadd_host_regs host_regs0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .s_cyc_i      (s_cyc_i),
        .s_stb_i      (s_stb_i),
        .s_we_i       (s_we_i),
        .s_adr_i      (s_adr_i),
        .s_dat_i      (s_dat_i),
        .s_sel_i      (s_sel_i),
        .spad_rdata_i (host_rdata),
        .s_dat_o      (s_dat_o),
        .s_ack_o      (s_ack_o),
        .start_o      (start),
        .dst_o        (dst),
        .nelem_o      (nelem),
        .a_addr_o     (a_addr),
        .b_addr_o     (b_addr),
        .sig_addr_o   (sig_addr),
        .spad_en_o    (host_en),
        .spad_we_o    (host_we),
        .spad_index_o (host_index),
        .spad_wdata_o (host_wdata),
        .spad_sel_o   (host_sel)
    );

    vvadd_engine engine0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .start_i      (start),
        .dst_i        (dst),
        .nelem_i      (nelem),
        .a_addr_i     (a_addr),
        .b_addr_i     (b_addr),
        .sig_addr_i   (sig_addr),
        .m_dat_i      (m_dat_i),
        .m_ack_i      (m_ack_i),
        .spad_rdata_i (eng_rdata),
        .m_cyc_o      (m_cyc_o),
        .m_stb_o      (m_stb_o),
        .m_we_o       (m_we_o),
        .m_adr_o      (m_adr_o),
        .m_dat_o      (m_dat_o),
        .spad_en_o    (eng_en),
        .spad_we_o    (eng_we),
        .spad_index_o (eng_index),
        .spad_wdata_o (eng_wdata)
    );

    vvadd_scratchpad spad0 (
        .clk_i        (clk_i),
        .host_en_i    (host_en),
        .host_we_i    (host_we),
        .host_index_i (host_index),
        .host_wdata_i (host_wdata),
        .host_sel_i   (host_sel),
        .eng_en_i     (eng_en),
        .eng_we_i     (eng_we),
        .eng_index_i  (eng_index),
        .eng_wdata_i  (eng_wdata),
        .host_rdata_o (host_rdata),
        .eng_rdata_o  (eng_rdata)
    );

endmodule

/* hdl/vvadd_scratchpad.sv */
// dual-port word scratchpad, byte-writable host port, word-wide engine port
module vvadd_scratchpad
    import vvadd_bus_pkg::*;
    import vvadd_xcel_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        host_en_i,
    input  logic                        host_we_i,
    input  logic [spad_index_width-1:0] host_index_i,
    input  logic [bus_data_width-1:0]   host_wdata_i,
    input  logic [bus_sel_width-1:0]    host_sel_i,
    input  logic                        eng_en_i,
    input  logic                        eng_we_i,
    input  logic [spad_index_width-1:0] eng_index_i,
    input  logic [bus_data_width-1:0]   eng_wdata_i,
    output logic [bus_data_width-1:0]   host_rdata_o,
    output logic [bus_data_width-1:0]   eng_rdata_o
);

    logic [bus_data_width-1:0] mem [spad_depth];

    // both ports in one process, engine write wins on a collision
    always_ff @(posedge clk_i) begin
        if (host_en_i) begin
            if (host_we_i) begin
                for (int b = 0; b < bus_sel_width; b++) begin
                    if (host_sel_i[b]) begin
                        mem[host_index_i][b*8 +: 8] <= host_wdata_i[b*8 +: 8];
                    end
                end
            end
            host_rdata_o <= mem[host_index_i];
        end

        if (eng_en_i) begin
            if (eng_we_i) begin
                mem[eng_index_i] <= eng_wdata_i;
            end
            // read-first, old word on a write
            eng_rdata_o <= mem[eng_index_i];
        end
    end

endmodule

/* hdl/vvadd_engine.sv */
// vvadd engine FSM: fetch A and B, add in place, signal completion
module vvadd_engine
    import vvadd_bus_pkg::*;
    import vvadd_xcel_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        start_i,
    input  logic [spad_index_width-1:0] dst_i,
    input  logic [count_width-1:0]      nelem_i,
    input  logic [bus_addr_width-1:0]   a_addr_i,
    input  logic [bus_addr_width-1:0]   b_addr_i,
    input  logic [bus_addr_width-1:0]   sig_addr_i,
    input  logic [bus_data_width-1:0]   m_dat_i,
    input  logic                        m_ack_i,
    input  logic [bus_data_width-1:0]   spad_rdata_i,
    output logic                        m_cyc_o,
    output logic                        m_stb_o,
    output logic                        m_we_o,
    output logic [bus_addr_width-1:0]   m_adr_o,
    output logic [bus_data_width-1:0]   m_dat_o,
    output logic                        spad_en_o,
    output logic                        spad_we_o,
    output logic [spad_index_width-1:0] spad_index_o,
    output logic [bus_data_width-1:0]   spad_wdata_o
);

    engine_state_e             state_r;
    engine_state_e             state_next;
    logic [count_width-1:0]    count_r;
    logic [bus_data_width-1:0] a_r;
    logic                      last_elem;
    logic                      step;
    logic                      bus_busy;
    logic [spad_index_width-1:0] a_index;
    logic [spad_index_width-1:0] b_index;

    assign last_elem = (count_r == nelem_i - 1'b1);

    // A sits at dst, B right after it
    assign a_index = dst_i + spad_index_width'(count_r);
    assign b_index = dst_i + spad_index_width'(nelem_i) + spad_index_width'(count_r);

    // ------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------

    always_comb begin
        state_next = state_r;
        case (state_r)
            idle: begin
                // empty vector skips straight to the completion write
                if (start_i) begin
                    state_next = (nelem_i == '0) ? signal : fetch_a;
                end
            end
            fetch_a: begin
                if (m_ack_i && last_elem) begin
                    state_next = fetch_b;
                end
            end
            fetch_b: begin
                if (m_ack_i && last_elem) begin
                    state_next = read_a;
                end
            end
            read_a: begin
                state_next = read_b;
            end
            read_b: begin
                state_next = write_sum;
            end
            write_sum: begin
                state_next = last_elem ? signal : read_a;
            end
            signal: begin
                if (m_ack_i) begin
                    state_next = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= idle;
        end else begin
            state_r <= state_next;
        end
    end

    // one counter serves all three element loops
    assign step = ((state_r == fetch_a || state_r == fetch_b) && m_ack_i)
                  || (state_r == write_sum);

    always_ff @(posedge clk_i) begin
        if (reset_i || state_r == idle) begin
            count_r <= '0;
        end else if (step) begin
            count_r <= last_elem ? '0 : count_r + 1'b1;
        end
    end

    // a arrives in read_b, b arrives in write_sum
    always_ff @(posedge clk_i) begin
        if (state_r == read_b) begin
            a_r <= spad_rdata_i;
        end
    end

    // ------------------------------------------------------------
    // scratchpad port 1
    // ------------------------------------------------------------

    always_comb begin
        spad_en_o    = 1'b0;
        spad_we_o    = 1'b0;
        spad_index_o = a_index;
        spad_wdata_o = m_dat_i;
        case (state_r)
            fetch_a: begin
                spad_en_o = m_ack_i;
                spad_we_o = 1'b1;
            end
            fetch_b: begin
                spad_en_o    = m_ack_i;
                spad_we_o    = 1'b1;
                spad_index_o = b_index;
            end
            read_a: begin
                spad_en_o = 1'b1;
            end
            read_b: begin
                spad_en_o    = 1'b1;
                spad_index_o = b_index;
            end
            write_sum: begin
                spad_en_o    = 1'b1;
                spad_we_o    = 1'b1;
                spad_wdata_o = a_r + spad_rdata_i;
            end
            default: begin
                spad_en_o = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------
    // wishbone master, one request at a time
    // ------------------------------------------------------------

    assign bus_busy = (state_r == fetch_a) || (state_r == fetch_b) || (state_r == signal);

    assign m_cyc_o = bus_busy;
    assign m_stb_o = bus_busy;
    assign m_we_o  = (state_r == signal);
    assign m_dat_o = bus_data_width'(1);

    always_comb begin
        case (state_r)
            fetch_a: m_adr_o = a_addr_i + bus_addr_width'(count_r);
            fetch_b: m_adr_o = b_addr_i + bus_addr_width'(count_r);
            default: m_adr_o = sig_addr_i;
        endcase
    end

    stb_within_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
        m_stb_o |-> m_cyc_o);

    // request must not move before the slave takes it
    req_held_until_ack: assert property (@(posedge clk_i) disable iff (reset_i)
        (m_stb_o && !m_ack_i) |=> (m_stb_o && $stable(m_adr_o) && $stable(m_we_o)));

endmodule

/* hdl/vvadd_host_regs.sv */
// wishbone slave decode, control registers and slave response mux
module vvadd_host_regs
    import vvadd_bus_pkg::*;
    import vvadd_xcel_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        s_cyc_i,
    input  logic                        s_stb_i,
    input  logic                        s_we_i,
    input  host_addr_u                  s_adr_i,
    input  logic [bus_data_width-1:0]   s_dat_i,
    input  logic [bus_sel_width-1:0]    s_sel_i,
    input  logic [bus_data_width-1:0]   spad_rdata_i,
    output logic [bus_data_width-1:0]   s_dat_o,
    output logic                        s_ack_o,
    output logic                        start_o,
    output logic [spad_index_width-1:0] dst_o,
    output logic [count_width-1:0]      nelem_o,
    output logic [bus_addr_width-1:0]   a_addr_o,
    output logic [bus_addr_width-1:0]   b_addr_o,
    output logic [bus_addr_width-1:0]   sig_addr_o,
    output logic                        spad_en_o,
    output logic                        spad_we_o,
    output logic [spad_index_width-1:0] spad_index_o,
    output logic [bus_data_width-1:0]   spad_wdata_o,
    output logic [bus_sel_width-1:0]    spad_sel_o
);

    logic [bus_data_width-1:0] csr_r [csr_count];
    logic [bus_data_width-1:0] csr_rdata_r;
    logic                      ack_r;
    logic                      rd_mem_r;
    logic                      start_r;
    logic                      req;
    logic                      csr_req;
    logic                      csr_hit;

    // a request is new until we ack it
    assign req     = s_cyc_i && s_stb_i && !ack_r;
    assign csr_req = req && !s_adr_i.csr.region;
    assign csr_hit = int'(s_adr_i.csr.index) < csr_count;

    // ------------------------------------------------------------
    // control registers
    // ------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < csr_count; i++) begin
                csr_r[i] <= '0;
            end
        end else if (csr_req && s_we_i && csr_hit) begin
            csr_r[s_adr_i.csr.index] <= s_dat_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (csr_req && !s_we_i) begin
            csr_rdata_r <= csr_hit ? csr_r[s_adr_i.csr.index] : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_r    <= 1'b0;
            rd_mem_r <= 1'b0;
            start_r  <= 1'b0;
        end else begin
            ack_r    <= req;
            rd_mem_r <= req && s_adr_i.mem.region;
            start_r  <= csr_req && s_we_i && (s_adr_i.csr.index == csr_cmd);
        end
    end

    assign start_o    = start_r;
    assign dst_o      = csr_r[csr_dst][spad_index_width-1:0];
    assign nelem_o    = csr_r[csr_nelem][count_width-1:0];
    assign a_addr_o   = csr_r[csr_a_addr];
    assign b_addr_o   = csr_r[csr_b_addr];
    assign sig_addr_o = csr_r[csr_sig_addr];

    // scratchpad port 0, data comes back with the ack
    assign spad_en_o    = req && s_adr_i.mem.region;
    assign spad_we_o    = s_we_i;
    assign spad_index_o = s_adr_i.mem.index;
    assign spad_wdata_o = s_dat_i;
    assign spad_sel_o   = s_sel_i;

    // response
    assign s_ack_o = ack_r;
    assign s_dat_o = rd_mem_r ? spad_rdata_i : csr_rdata_r;

    ack_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
        s_ack_o |=> !s_ack_o);

endmodule

/* hdl/vvadd_xcel_pkg.sv */
// control register indices, scratchpad sizing and engine state type
package vvadd_xcel_pkg;

    // ------------------------------------------------------------
    // scratchpad and vector sizing
    // ------------------------------------------------------------

    localparam int spad_depth       = 64;
    localparam int spad_index_width = $clog2(spad_depth);
    localparam int max_elements     = 32;

    // element counter must reach max_elements itself
    localparam int count_width = $clog2(max_elements + 1);

    // ------------------------------------------------------------
    // control register map
    // ------------------------------------------------------------

    localparam logic [2:0] csr_cmd      = 3'd0;
    localparam logic [2:0] csr_dst      = 3'd1;
    localparam logic [2:0] csr_nelem    = 3'd2;
    localparam logic [2:0] csr_a_addr   = 3'd3;
    localparam logic [2:0] csr_b_addr   = 3'd4;
    localparam logic [2:0] csr_sig_addr = 3'd5;

    // indices at or above this are unmapped
    localparam int csr_count = 6;

    // ------------------------------------------------------------
    // engine FSM
    // ------------------------------------------------------------

    typedef enum logic [3:0] {
        idle      = 4'd0,
        fetch_a   = 4'd1,
        fetch_b   = 4'd2,
        read_a    = 4'd3,
        read_b    = 4'd4,
        write_sum = 4'd5,
        signal    = 4'd6
    } engine_state_e;

endpackage

/* hdl/vvadd_bus_pkg.sv */
// bus widths and the host address union for the vvadd accelerator
package vvadd_bus_pkg;

    // wishbone data, master address and byte select widths
    localparam int bus_data_width = 32;
    localparam int bus_addr_width = 32;
    localparam int bus_sel_width  = bus_data_width / 8;

    // host slave address fields
    localparam int host_csr_index_width = 3;
    localparam int host_mem_index_width = 6;

    // register view, region bit clear
    typedef struct packed {
        logic                            region;
        logic [3:0]                      unused;
        logic [host_csr_index_width-1:0] index;
    } host_csr_view_t;

    // scratchpad view, region bit set
    typedef struct packed {
        logic                            region;
        logic                            unused;
        logic [host_mem_index_width-1:0] index;
    } host_mem_view_t;

    typedef union packed {
        host_csr_view_t csr;
        host_mem_view_t mem;
    } host_addr_u;

endpackage
